// ==== vlog.f ====
verilog/obj_pkg.sv
verilog/obj_frame_copy.sv
verilog/obj_table.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/mem_arbiter.sv
verilog/obj_line_buf.sv
verilog/obj_engine.sv
dv/obj_mem_model.sv
dv/obj_engine_tb.sv

// ==== dv/obj_engine_tb.sv ====
// directed tests with fixed-length lines; pxl_cen runs at half the clock and hdump is driven aligned
`timescale 1ns/10ps

module obj_engine_tb;
    import obj_pkg::*;

    localparam int NOBJ = 32;
    localparam int LINE_CYC = 1040;         // line_start plus a 512-pixel sweep
    localparam int COPY_MAX = 2000;         // 128 reads with up to 4 cycles delay each
    localparam int FRAME_CYC = COPY_MAX + 8 * LINE_CYC;
    localparam int unsigned RNG_SEED = 32'hf3bfaeb8;

    logic               clk;
    logic               rst;
    logic               pxl_cen;
    logic               frame_start;
    logic               obank;
    logic               line_start;
    logic [8:0]         vrender;
    logic [8:0]         vdump;
    logic [8:0]         hdump;
    logic               mem_req;
    logic               mem_ack;
    mem_req_t           mem_addr;
    logic [MEM_DW-1:0]  mem_data;
    logic               frame_busy;
    logic [PXL_W-1:0]   pxl;

    obj_entry_t         ref_tbl [2][NOBJ];  // both banks as loaded into memory
    logic [PXL_W-1:0]   exp_line [512];
    logic               cur_bank;
    int                 mism_cnt;
    int                 fail_cnt;

    obj_engine #(.NOBJ(NOBJ)) obj_engine_i (
        .clk, .rst, .pxl_cen, .frame_start, .obank, .line_start,
        .vrender, .vdump, .hdump, .mem_req, .mem_addr, .mem_ack, .mem_data,
        .frame_busy, .pxl
    );

    obj_mem_model #(.SEED(RNG_SEED)) mem_model (
        .clk, .mem_req, .mem_addr, .mem_ack, .mem_data
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        pxl_cen <= ~pxl_cen;                // high every second cycle

    initial begin
        repeat (20 * FRAME_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", 20 * FRAME_CYC);
        $display("Test failures found");
        $finish;
    end

    task automatic check_equal(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (got !== exp) begin
            mism_cnt++;
            $display("mismatch %s: expected %h got %h", name, exp, got);
        end
    endtask

    task automatic set_obj(input bit bank, input int n, input logic [8:0] x, input logic [8:0] y,
                           input logic [15:0] code, input logic [15:0] attr);
        mem_req_t   base;
        obj_entry_t e;
        base   = mem_req_t'(bank * ORAM_BANK_STRIDE + 4 * n);
        e.x    = x;
        e.y    = y;
        e.code = code;
        e.attr = attr;
        ref_tbl[bank][n] = e;
        mem_model.mem[base]     = {7'd0, x};
        mem_model.mem[base + 1] = {7'd0, y};
        mem_model.mem[base + 2] = code;
        mem_model.mem[base + 3] = attr;
    endtask

    task automatic clear_tables();
        for (int b = 0; b < 2; b++)
            for (int n = 0; n < NOBJ; n++)
                set_obj(b[0], n, 9'd0, 9'd300, 16'd0, 16'd0);   // parked below tested lines
    endtask

    // nibble pattern leaves a transparent pixel in every row
    task automatic load_gfx(input logic [15:0] code);
        logic [15:0] w;
        mem_req_t    a;
        for (int r = 0; r < 16; r++) begin
            for (int k = 0; k < 4; k++) begin
                for (int j = 0; j < 4; j++)
                    w[4*j +: 4] = 4'((code * 5 + r * 3 + (4 * k + j) * 7) % 13);
                a = ROM_BASE + mem_req_t'(code * 64 + r * 4 + k);
                mem_model.mem[a] = w;
            end
        end
    endtask

    // expected line from the table and graphics layout, lowest index drawn first
    task automatic build_ref(input logic [8:0] line);
        obj_entry_t  e;
        logic [8:0]  dy;
        logic [8:0]  pos;
        logic [15:0] w;
        logic [3:0]  col;
        for (int p = 0; p < 512; p++)
            exp_line[p] = '0;
        for (int n = 0; n < NOBJ; n++) begin
            e  = ref_tbl[cur_bank][n];
            dy = line - e.y;                // mod 512
            if (dy < OBJ_H) begin
                for (int i = 0; i < 16; i++) begin
                    w   = mem_model.mem[ROM_BASE + mem_req_t'(e.code * 64 + dy * 4 + i / 4)];
                    col = w[4*(i%4) +: 4];
                    pos = e.attr[ATTR_HFLIP] ? e.x + 15 - i : e.x + i;
                    if (col != 4'd0 && exp_line[pos] == '0)
                        exp_line[pos] = {e.attr[4:0], col};
                end
            end
        end
    endtask

    task automatic load_frame(input bit bank);
        int cyc;
        cur_bank    = bank;
        obank       <= bank;
        frame_start <= 1'b1;
        @(posedge clk);
        frame_start <= 1'b0;
        @(posedge clk);
        if (!frame_busy) begin
            fail_cnt++;
            $display("frame_busy did not rise after frame_start");
        end
        cyc = 0;
        while (frame_busy && cyc < COPY_MAX) begin
            @(posedge clk);
            cyc++;
        end
        if (frame_busy) begin
            fail_cnt++;
            $display("table copy still busy after %0d cycles", COPY_MAX);
        end
    endtask

    // render line v while line v-1 is shown and optionally checked
    task automatic run_line(input logic [8:0] v, input bit check);
        if (check)
            build_ref(v - 9'd1);
        while (pxl_cen)
            @(posedge clk);                 // next edge carries pxl_cen
        vrender    <= v;
        vdump      <= v - 9'd1;             // read bank and hdump 0 meet on the first load
        hdump      <= 9'd0;
        line_start <= 1'b1;
        for (int h = 0; h < 512; h++) begin
            @(posedge clk);                 // load edge
            line_start <= 1'b0;
            @(posedge clk);                 // pxl settled
            if (check && pxl !== exp_line[h]) begin
                mism_cnt++;
                $display("mismatch pxl at line %0d hdump %0d: expected %h got %h",
                         v - 9'd1, h, exp_line[h], pxl);
            end
            hdump <= 9'(h + 1);
        end
    endtask

    task automatic blank_lines();
        run_line(9'd480, 1'b0);             // shows and clears both banks
        run_line(9'd481, 1'b0);
    endtask

    task automatic check_lines(input logic [8:0] first, input int count);
        run_line(first, 1'b0);
        for (int k = 1; k <= count; k++)
            run_line(first + 9'(k), 1'b1);
    endtask

    task automatic reset_values();
        check_equal("mem_req", 16'd0, {15'd0, mem_req});
        check_equal("frame_busy", 16'd0, {15'd0, frame_busy});
        check_equal("pxl", 16'd0, {7'd0, pxl});
    endtask

    task automatic single_object();
        clear_tables();
        load_gfx(16'd5);
        set_obj(1'b0, 0, 9'd100, 9'd40, 16'd5, 16'h0003);
        load_frame(1'b0);
        blank_lines();
        check_lines(9'd39, 18);             // one line above to one below
    endtask

    task automatic hflip_wrap();
        clear_tables();
        load_gfx(16'd6);
        set_obj(1'b0, 0, 9'd505, 9'd60, 16'd6, 16'h0107);  // crosses 511
        load_frame(1'b0);
        blank_lines();
        check_lines(9'd62, 2);
    endtask

    task automatic overlap_priority();
        clear_tables();
        load_gfx(16'd5);
        load_gfx(16'd6);
        set_obj(1'b0, 0, 9'd200, 9'd80, 16'd5, 16'h0002);
        set_obj(1'b0, 1, 9'd208, 9'd84, 16'd6, 16'h0009);
        load_frame(1'b0);
        blank_lines();
        check_lines(9'd85, 3);
    endtask

    task automatic bank_select();
        clear_tables();
        load_gfx(16'd5);
        load_gfx(16'd6);
        set_obj(1'b0, 0, 9'd50, 9'd120, 16'd5, 16'h0001);
        set_obj(1'b1, 0, 9'd300, 9'd120, 16'd6, 16'h0104);
        load_frame(1'b1);
        blank_lines();
        check_lines(9'd124, 1);
        load_frame(1'b0);                   // second frame, other bank
        blank_lines();
        check_lines(9'd124, 1);
    endtask

    task automatic clear_on_read();
        clear_tables();
        load_gfx(16'd5);
        set_obj(1'b0, 3, 9'd150, 9'd150, 16'd5, 16'h0105);
        load_frame(1'b0);
        blank_lines();
        check_lines(9'd165, 3);             // last row, then two empty lines
    endtask

    initial begin
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        frame_start = 1'b0;
        obank       = 1'b0;
        line_start  = 1'b0;
        vrender     = '0;
        vdump       = '0;
        hdump       = '0;
        cur_bank    = 1'b0;
        mism_cnt    = 0;
        fail_cnt    = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_values();
        single_object();
        hflip_wrap();
        overlap_priority();
        bank_select();
        clear_on_read();
        $display("%0d mismatches, %0d other errors", mism_cnt, fail_cnt);
        if (mism_cnt + fail_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== dv/obj_mem_model.sv ====
// one four-phase read at a time, ack after 1 to 4 cycles; words never written by the testbench read as X
`timescale 1ns/10ps

module obj_mem_model #(
    parameter int unsigned SEED = 32'h1
) (
    input                                   clk,
    input                                   mem_req,
    input  obj_pkg::mem_req_t               mem_addr,
    output logic                            mem_ack,
    output logic [obj_pkg::MEM_DW-1:0]      mem_data
);
    import obj_pkg::*;

    logic [MEM_DW-1:0] mem [1 << MEM_AW];   // full 20-bit word space
    int unsigned       delay;
    int unsigned       seed_ret;

    initial begin
        mem_ack  = 1'b0;
        mem_data = '0;
        seed_ret = $urandom(SEED);          // seeded once, start of run
        forever begin
            @(posedge clk);
            if (mem_req && !mem_ack) begin
                delay = 1 + $urandom % 4;
                repeat (delay - 1) @(posedge clk);
                mem_ack  <= 1'b1;
                mem_data <= mem[mem_addr];  // held while ack is high
                @(posedge clk);
                while (mem_req)
                    @(posedge clk);         // requester drops req after seeing ack
                mem_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/obj_engine.sv ====
// hdump must arrive already aligned and vrender must equal vdump + 1; only vdump bit 0 is used
`timescale 1ns/10ps

module obj_engine #(
    parameter int NOBJ = 32
) (
    input                               clk,
    input                               rst,
    input                               pxl_cen,
    input                               frame_start,
    input                               obank,
    input                               line_start,
    input        [8:0]                  vrender,
    input        [8:0]                  vdump,
    input        [8:0]                  hdump,
    output logic                        mem_req,
    output obj_pkg::mem_req_t           mem_addr,
    input                               mem_ack,
    input        [obj_pkg::MEM_DW-1:0]  mem_data,
    output logic                        frame_busy,
    output logic [obj_pkg::PXL_W-1:0]   pxl
);
    import obj_pkg::*;

    // memory clients
    logic               copy_req;
    logic               copy_ack;
    mem_req_t           copy_addr;
    logic               draw_req;
    logic               draw_ack;
    mem_req_t           draw_addr;

    // object table
    logic                       tbl_we;
    logic [$clog2(NOBJ)-1:0]    tbl_waddr;
    obj_entry_t                 tbl_wdata;
    logic [$clog2(NOBJ)-1:0]    tbl_raddr;
    obj_entry_t                 tbl_rdata;

    // scan to draw, draw to line buffer
    logic               cmd_req;
    logic               cmd_ack;
    draw_cmd_t          cmd;
    logic               buf_wr;
    logic [8:0]         buf_addr;
    logic [PXL_W-1:0]   buf_data;

    obj_frame_copy #(.NOBJ(NOBJ)) u_frame (
        .clk, .rst, .frame_start, .obank,
        .copy_req, .copy_addr, .copy_ack, .mem_data,
        .frame_busy, .tbl_we, .tbl_waddr, .tbl_wdata
    );

    obj_table #(.NOBJ(NOBJ)) u_table (
        .clk, .tbl_we, .tbl_waddr, .tbl_wdata, .tbl_raddr, .tbl_rdata
    );

    obj_scan #(.NOBJ(NOBJ)) u_scan (
        .clk, .rst, .line_start, .vrender,
        .tbl_raddr, .tbl_rdata, .cmd_req, .cmd, .cmd_ack
    );

    obj_draw u_draw (
        .clk, .rst, .cmd_req, .cmd, .cmd_ack,
        .draw_req, .draw_addr, .draw_ack, .mem_data,
        .buf_wr, .buf_addr, .buf_data
    );

    mem_arbiter u_arb (
        .clk, .rst,
        .copy_req, .copy_addr, .copy_ack,
        .draw_req, .draw_addr, .draw_ack,
        .mem_req, .mem_addr, .mem_ack
    );

    obj_line_buf u_line (
        .clk, .rst, .pxl_cen,
        .vrender_lsb ( vrender[0] ),
        .vdump_lsb   ( vdump[0]   ),
        .hdump, .buf_wr, .buf_addr, .buf_data, .pxl
    );

endmodule

// ==== verilog/obj_line_buf.sv ====
// vrender and vdump must differ in bit 0; contents are undefined until both banks are shown once
`timescale 1ns/10ps

module obj_line_buf (
    input                               clk,
    input                               rst,
    input                               pxl_cen,
    input                               vrender_lsb,    // write bank
    input                               vdump_lsb,      // read bank
    input        [8:0]                  hdump,
    input                               buf_wr,
    input        [8:0]                  buf_addr,
    input        [obj_pkg::PXL_W-1:0]   buf_data,
    output logic [obj_pkg::PXL_W-1:0]   pxl
);
    import obj_pkg::*;

    logic [PXL_W-1:0] mem [1024];   // bank in the top address bit
    logic [9:0]       wr_idx;
    logic [9:0]       rd_idx;
    logic [PXL_W-1:0] wr_old;       // current content at the write spot
    logic             wr_free;

    assign wr_idx  = {vrender_lsb, buf_addr};
    assign rd_idx  = {vdump_lsb, hdump};
    assign wr_old  = mem[wr_idx];
    assign wr_free = wr_old[3:0] == 4'd0;   // first writer wins

    // draw side writes, display side clears behind itself
    always_ff @(posedge clk) begin
        if (buf_wr && wr_free)
            mem[wr_idx] <= buf_data;
        if (pxl_cen)
            mem[rd_idx] <= '0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pxl <= '0;
        else if (pxl_cen)
            pxl <= mem[rd_idx];     // old value, cleared on the same edge
    end

endmodule

// ==== verilog/mem_arbiter.sv ====
// clients must hold req until ack and keep it low until their ack falls
`timescale 1ns/10ps

module mem_arbiter (
    input                       clk,
    input                       rst,

    // frame copier, higher priority
    input                       copy_req,
    input  obj_pkg::mem_req_t   copy_addr,
    output logic                copy_ack,

    // drawer
    input                       draw_req,
    input  obj_pkg::mem_req_t   draw_addr,
    output logic                draw_ack,

    // external memory port
    output logic                mem_req,
    output obj_pkg::mem_req_t   mem_addr,
    input                       mem_ack
);
    logic lock;         // grant held
    logic owner;        // 0 copier, 1 drawer
    logic owner_req;

    assign owner_req = owner ? draw_req : copy_req;
    assign mem_req   = lock && owner_req;
    assign mem_addr  = owner ? draw_addr : copy_addr;
    assign copy_ack  = lock && !owner && mem_ack;   // ack goes to the owner only
    assign draw_ack  = lock &&  owner && mem_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            lock  <= 1'b0;
            owner <= 1'b0;
        end else if (!lock) begin
            if (copy_req) begin
                lock  <= 1'b1;
                owner <= 1'b0;
            end else if (draw_req) begin
                lock  <= 1'b1;
                owner <= 1'b1;
            end
        end else if (!owner_req && !mem_ack) begin
            lock <= 1'b0;   // handshake closed
        end
    end

    // a memory ack lands inside a grant, so exactly one client sees it
    a_one_ack: assert property (@(posedge clk) disable iff (rst)
        mem_ack |-> (copy_ack != draw_ack))
        else $error("memory ack arrived outside a granted handshake");

    // the memory sees one client for the whole four phases
    a_owner_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_req || mem_ack) |=> $stable(owner))
        else $error("grant moved during an open memory handshake");

endmodule

// ==== verilog/obj_draw.sv ====
// object codes above 15359 wrap past the top of the 20-bit map; one command in flight at a time
`timescale 1ns/10ps

module obj_draw (
    input                               clk,
    input                               rst,
    input                               cmd_req,
    input  obj_pkg::draw_cmd_t          cmd,
    output logic                        cmd_ack,
    output logic                        draw_req,
    output obj_pkg::mem_req_t           draw_addr,
    input                               draw_ack,
    input        [obj_pkg::MEM_DW-1:0]  mem_data,
    output logic                        buf_wr,
    output logic [8:0]                  buf_addr,
    output logic [obj_pkg::PXL_W-1:0]   buf_data
);
    import obj_pkg::*;

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_REQ   = 3'd1;    // wait for memory ack low
    localparam logic [2:0] ST_FETCH = 3'd2;
    localparam logic [2:0] ST_PIX   = 3'd3;
    localparam logic [2:0] ST_DONE  = 3'd4;    // cmd_ack high

    draw_cmd_t          cur;        // latched command
    logic [2:0]         st;
    logic [1:0]         word;       // row word k
    logic [1:0]         nib;        // pixel within the word
    logic [MEM_DW-1:0]  shreg;      // pixel 4k in the low nibble
    logic [3:0]         pix_idx;
    logic [8:0]         pix_ofs;

    assign pix_idx   = {word, nib};
    // 15 - i is the bitwise inverse on 4 bits
    assign pix_ofs   = cur.attr[ATTR_HFLIP] ? {5'd0, ~pix_idx} : {5'd0, pix_idx};
    assign draw_addr = ROM_BASE + mem_req_t'({cur.code, cur.row, word});

    always_ff @(posedge clk) begin
        if (rst) begin
            st       <= ST_IDLE;
            cmd_ack  <= 1'b0;
            draw_req <= 1'b0;
            buf_wr   <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
            case (st)
                ST_IDLE: if (cmd_req && !cmd_ack) begin
                    cur  <= cmd;
                    word <= 2'd0;
                    st   <= ST_REQ;
                end
                ST_REQ: if (!draw_ack) begin
                    draw_req <= 1'b1;
                    st       <= ST_FETCH;
                end
                ST_FETCH: if (draw_ack) begin
                    draw_req <= 1'b0;
                    shreg    <= mem_data;
                    nib      <= 2'd0;
                    st       <= ST_PIX;
                end
                ST_PIX: begin
                    buf_wr   <= shreg[3:0] != 4'd0;     // skip transparent
                    buf_addr <= cur.hpos + pix_ofs;     // wraps mod 512
                    buf_data <= {cur.attr[ATTR_PAL_W-1:0], shreg[3:0]};
                    shreg    <= shreg >> 4;
                    nib      <= nib + 2'd1;
                    if (nib == 2'd3) begin
                        word <= word + 2'd1;
                        if (word == 2'd3) begin
                            cmd_ack <= 1'b1;            // whole row written
                            st      <= ST_DONE;
                        end else begin
                            st <= ST_REQ;
                        end
                    end
                end
                ST_DONE: if (!cmd_req) begin
                    cmd_ack <= 1'b0;
                    st      <= ST_IDLE;
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // a zero colour would block later objects in the priority check of the line buffer
    a_no_transparent: assert property (@(posedge clk) disable iff (rst)
        buf_wr |-> buf_data[3:0] != 4'd0)
        else $error("transparent pixel written to the line buffer");

endmodule

// ==== verilog/obj_scan.sv ====
// NOBJ must be a power of two; line_start is only taken while idle, so lines must outlast the scan
`timescale 1ns/10ps

module obj_scan #(
    parameter int NOBJ = 32
) (
    input                               clk,
    input                               rst,
    input                               line_start,
    input        [8:0]                  vrender,
    output logic [$clog2(NOBJ)-1:0]     tbl_raddr,
    input  obj_pkg::obj_entry_t         tbl_rdata,
    output logic                        cmd_req,
    output obj_pkg::draw_cmd_t          cmd,
    input                               cmd_ack
);
    import obj_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_READ = 2'd1;     // wait for table data
    localparam logic [1:0] ST_TEST = 2'd2;
    localparam logic [1:0] ST_SEND = 2'd3;     // command handshake open

    logic [1:0] st;
    logic [8:0] vline;      // line being rendered, held for the scan
    logic [8:0] dy;
    logic       visible;

    assign dy      = vline - tbl_rdata.y;       // wraps mod 512
    assign visible = dy < 9'(OBJ_H);

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= ST_IDLE;
            cmd_req   <= 1'b0;
            tbl_raddr <= '0;
        end else begin
            case (st)
                ST_IDLE: if (line_start) begin
                    vline     <= vrender;
                    tbl_raddr <= '0;
                    st        <= ST_READ;
                end
                ST_READ: st <= ST_TEST;
                ST_TEST: begin
                    if (visible) begin
                        cmd.code <= tbl_rdata.code;
                        cmd.attr <= tbl_rdata.attr;
                        cmd.hpos <= tbl_rdata.x;
                        cmd.row  <= dy[3:0];
                        cmd_req  <= 1'b1;
                        st       <= ST_SEND;
                    end else begin
                        tbl_raddr <= tbl_raddr + 1'd1;
                        st        <= &tbl_raddr ? ST_IDLE : ST_READ;
                    end
                end
                default: begin                  // ST_SEND, drawer back-pressure
                    if (cmd_req && cmd_ack) begin
                        cmd_req <= 1'b0;
                    end else if (!cmd_req && !cmd_ack) begin
                        tbl_raddr <= tbl_raddr + 1'd1;
                        st        <= &tbl_raddr ? ST_IDLE : ST_READ;
                    end
                end
            endcase
        end
    end

endmodule

// ==== verilog/obj_table.sv ====
// read and write in the same cycle to one entry returns the old entry
`timescale 1ns/10ps

module obj_table #(
    parameter int NOBJ = 32
) (
    input                               clk,

    // copier side
    input                               tbl_we,
    input        [$clog2(NOBJ)-1:0]     tbl_waddr,
    input  obj_pkg::obj_entry_t         tbl_wdata,

    // scanner side, one cycle read latency
    input        [$clog2(NOBJ)-1:0]     tbl_raddr,
    output obj_pkg::obj_entry_t         tbl_rdata
);
    import obj_pkg::*;

    obj_entry_t mem [NOBJ];     // whole entry per word, 50 bits wide

    // write port, filled once per frame
    always_ff @(posedge clk) begin
        if (tbl_we)
            mem[tbl_waddr] <= tbl_wdata;
    end

    // registered read
    always_ff @(posedge clk) begin
        tbl_rdata <= mem[tbl_raddr];
    end

endmodule

// ==== verilog/obj_frame_copy.sv ====
// NOBJ must be a power of two up to 256; frame_start pulses that arrive while busy are dropped
`timescale 1ns/10ps

module obj_frame_copy #(
    parameter int NOBJ = 32
) (
    input                               clk,
    input                               rst,
    input                               frame_start,
    input                               obank,
    output logic                        copy_req,
    output obj_pkg::mem_req_t           copy_addr,
    input                               copy_ack,
    input        [obj_pkg::MEM_DW-1:0]  mem_data,
    output logic                        frame_busy,
    output logic                        tbl_we,
    output logic [$clog2(NOBJ)-1:0]     tbl_waddr,
    output obj_pkg::obj_entry_t         tbl_wdata
);
    import obj_pkg::*;

    logic       bank;       // bank latched at frame_start
    logic [1:0] word;       // word within the entry: x, y, code, attr

    // entry index doubles as table write address
    assign copy_addr = (bank ? mem_req_t'(ORAM_BANK_STRIDE) : '0)
                     + mem_req_t'({tbl_waddr, word});

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_busy <= 1'b0;
            copy_req   <= 1'b0;
            tbl_we     <= 1'b0;
        end else begin
            tbl_we <= 1'b0;
            if (!frame_busy) begin
                if (frame_start) begin
                    frame_busy <= 1'b1;
                    bank       <= obank;
                    tbl_waddr  <= '0;
                    word       <= 2'd0;
                end
            end else if (copy_req) begin
                if (copy_ack) begin             // data valid while ack is high
                    copy_req <= 1'b0;
                    word     <= word + 2'd1;
                    case (word)
                        2'd0:    tbl_wdata.x    <= mem_data[8:0];
                        2'd1:    tbl_wdata.y    <= mem_data[8:0];
                        2'd2:    tbl_wdata.code <= mem_data;
                        default: tbl_wdata.attr <= mem_data;
                    endcase
                    tbl_we <= word == 2'd3;     // entry complete
                end
            end else if (tbl_we) begin
                tbl_waddr <= tbl_waddr + 1'd1;
                if (&tbl_waddr)
                    frame_busy <= 1'b0;         // last entry just written
            end else if (!copy_ack) begin
                copy_req <= 1'b1;               // previous ack gone, next word
            end
        end
    end

    // the arbiter forwards copy_addr straight to memory while the request is open
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        copy_req && !copy_ack |=> $stable(copy_addr))
        else $error("copy_addr changed during an open request");

endmodule

// ==== verilog/obj_pkg.sv ====
// shared widths, memory map and structs; table and graphics maps assume 16-bit memory words
package obj_pkg;

    // external memory port
    localparam int MEM_AW = 20;     // word address
    localparam int MEM_DW = 16;     // word width

    // line buffer pixel: 5-bit palette above 4-bit colour
    localparam int PXL_W = 9;

    // all objects are square, 16 lines by 16 pixels
    localparam int OBJ_H = 16;

    // object table banks, 4 words per entry
    localparam int ORAM_BANK_STRIDE = 1024;

    // graphics base, 64 words per object code (16 rows of 4 words)
    localparam logic [MEM_AW-1:0] ROM_BASE = 20'h10000;

    // attr field positions
    localparam int ATTR_HFLIP = 8;  // mirror the row
    localparam int ATTR_PAL_W = 5;  // palette sits in attr[4:0]

    // one object table entry, as copied from memory words 0..3
    typedef struct packed {
        logic [8:0]  x;         // word 0
        logic [8:0]  y;         // word 1
        logic [15:0] code;      // word 2
        logic [15:0] attr;      // word 3
    } obj_entry_t;

    // scanner to drawer, one per visible object
    typedef struct packed {
        logic [15:0] code;
        logic [15:0] attr;
        logic [8:0]  hpos;      // leftmost pixel on the line
        logic [3:0]  row;       // row inside the object
    } draw_cmd_t;

    // memory request payload is just the word address
    typedef logic [MEM_AW-1:0] mem_req_t;

endpackage
